// File: logic/dataPathPkg.sv
// bus and register sizes plus bus source encoding; modules take their widths as parameters
package dataPathPkg;

    localparam int dataWidth = 32;     // bus and register width
    localparam int regCount = 16;      // general registers
    localparam int regIndexWidth = 4;  // enough to index regCount

    // bus drivers, listed in busMux priority order after none
    typedef enum logic [3:0] {
        none     = 4'd0,
        regFile  = 4'd1,
        pc       = 4'd2,
        ir       = 4'd3,
        y        = 4'd4,
        zHigh    = 4'd5,
        zLow     = 4'd6,
        mar      = 4'd7,
        hi       = 4'd8,
        lo       = 4'd9,
        mdr      = 4'd10,
        external = 4'd11
    } busSource;

endpackage

// File: logic/aluPkg.sv
// ALU opcodes and sequencer states; opcode values are fixed, only opShl matches the old encoding
package aluPkg;

    typedef enum logic [4:0] {
        opAdd = 5'd0,
        opSub = 5'd1,
        opAnd = 5'd2,
        opOr  = 5'd3,
        opShr = 5'd4,
        opRor = 5'd6,
        opRol = 5'd7,
        opNeg = 5'd8,   // unary, acts on B
        opNot = 5'd9,   // unary, acts on B
        opMul = 5'd10,
        opDiv = 5'd11,
        opShl = 5'd24
    } aluOp;

    // multiply and divide sequencer
    typedef enum logic [1:0] {
        idle    = 2'd0,
        iterate = 2'd1,
        done    = 2'd2
    } aluState;

endpackage

// File: logic/busIf.sv
// shared datapath bus; only busMux drives value, every other block just reads it
`timescale 1ns/1ps

interface busIf #(
    parameter int DataWidth = 32
);
    logic [DataWidth-1:0] value;  // current bus contents

    // output strobes, one per source
    logic rfOut;
    logic pcOut;
    logic irOut;
    logic yOut;
    logic zHighOut;
    logic zLowOut;
    logic marOut;
    logic hiOut;
    logic loOut;
    logic mdrOut;
    logic extOut;

    modport mux (
        output value,
        input rfOut, pcOut, irOut, yOut, zHighOut, zLowOut,
        input marOut, hiOut, loOut, mdrOut, extOut
    );

    modport reader (input value);
endinterface

// File: logic/busMux.sv
// combinational bus driver; several strobes at once resolve by fixed priority, none gives zero
`timescale 1ns/1ps

module busMux #(
    parameter int DataWidth = 32
) (
    busIf.mux bus,
    input logic [DataWidth-1:0] regFileData,
    input logic [DataWidth-1:0] pcData,
    input logic [DataWidth-1:0] irData,
    input logic [DataWidth-1:0] yData,
    input logic [DataWidth-1:0] zHighData,
    input logic [DataWidth-1:0] zLowData,
    input logic [DataWidth-1:0] marData,
    input logic [DataWidth-1:0] hiData,
    input logic [DataWidth-1:0] loData,
    input logic [DataWidth-1:0] mdrData,
    input logic [DataWidth-1:0] extData
);
    dataPathPkg::busSource source;

    // first strobe in this list wins
    always_comb begin
        case (1'b1)
            bus.rfOut:    source = dataPathPkg::regFile;
            bus.pcOut:    source = dataPathPkg::pc;
            bus.irOut:    source = dataPathPkg::ir;
            bus.yOut:     source = dataPathPkg::y;
            bus.zHighOut: source = dataPathPkg::zHigh;
            bus.zLowOut:  source = dataPathPkg::zLow;
            bus.marOut:   source = dataPathPkg::mar;
            bus.hiOut:    source = dataPathPkg::hi;
            bus.loOut:    source = dataPathPkg::lo;
            bus.mdrOut:   source = dataPathPkg::mdr;
            bus.extOut:   source = dataPathPkg::external;
            default:      source = dataPathPkg::none;
        endcase
    end

    always_comb begin
        case (source)
            dataPathPkg::regFile:  bus.value = regFileData;
            dataPathPkg::pc:       bus.value = pcData;
            dataPathPkg::ir:       bus.value = irData;
            dataPathPkg::y:        bus.value = yData;
            dataPathPkg::zHigh:    bus.value = zHighData;
            dataPathPkg::zLow:     bus.value = zLowData;
            dataPathPkg::mar:      bus.value = marData;
            dataPathPkg::hi:       bus.value = hiData;
            dataPathPkg::lo:       bus.value = loData;
            dataPathPkg::mdr:      bus.value = mdrData;
            dataPathPkg::external: bus.value = extData;
            default:               bus.value = '0;  // idle bus reads zero
        endcase
    end
endmodule

// File: logic/registerFile.sv
// general registers; one select index serves both the read port and the bus write
`timescale 1ns/1ps

module registerFile #(
    parameter int DataWidth = 32,
    parameter int RegCount = 16
) (
    input logic Clock,
    input logic rstN,
    busIf.reader bus,
    input logic [dataPathPkg::regIndexWidth-1:0] rfSelect,
    input logic rfIn,
    output logic [DataWidth-1:0] readData
);
    logic [DataWidth-1:0] regs [RegCount];

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (rfIn) begin
            regs[rfSelect] <= bus.value;  // write from bus
        end
    end

    assign readData = regs[rfSelect];  // presented to busMux
endmodule

// File: logic/memoryInterface.sv
// MAR and MDR only, no memory behind them; read steers the MDR to memDataIn instead of the bus
`timescale 1ns/1ps

module memoryInterface #(
    parameter int DataWidth = 32
) (
    input logic Clock,
    input logic rstN,
    busIf.reader bus,
    input logic marIn,
    input logic mdrIn,
    input logic read,
    input logic [DataWidth-1:0] memDataIn,
    output logic [DataWidth-1:0] marData,
    output logic [DataWidth-1:0] mdrData
);
    logic [DataWidth-1:0] mdrNext;

    assign mdrNext = read ? memDataIn : bus.value;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            marData <= '0;
            mdrData <= '0;
        end else begin
            if (marIn) marData <= bus.value;  // address always comes from the bus
            if (mdrIn) mdrData <= mdrNext;
        end
    end
endmodule

// File: logic/specialRegisters.sv
// PC, IR, Y, HI and LO as plain bus-loaded registers; no PC increment, no IR decode
`timescale 1ns/1ps

module specialRegisters #(
    parameter int DataWidth = 32
) (
    input logic Clock,
    input logic rstN,
    busIf.reader bus,
    input logic pcIn,
    input logic irIn,
    input logic yIn,
    input logic hiIn,
    input logic loIn,
    output logic [DataWidth-1:0] pcData,
    output logic [DataWidth-1:0] irData,
    output logic [DataWidth-1:0] yData,
    output logic [DataWidth-1:0] hiData,
    output logic [DataWidth-1:0] loData
);
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            pcData <= '0;
            irData <= '0;
            yData <= '0;
            hiData <= '0;
            loData <= '0;
        end else begin
            if (pcIn) begin
                pcData <= bus.value;
            end
            if (irIn) begin
                irData <= bus.value;
            end
            if (yIn) begin
                yData <= bus.value;  // also the ALU A operand
            end
            if (hiIn) begin
                hiData <= bus.value;
            end
            if (loIn) begin
                loData <= bus.value;
            end
        end
    end
endmodule

// File: logic/alu.sv
// unsigned mul/div take DataWidth+1 cycles, one op at a time; start while busy is dropped
`timescale 1ns/1ps

module alu #(
    parameter int DataWidth = 32
) (
    input logic Clock,
    input logic rstN,
    busIf.reader bus,
    input logic [DataWidth-1:0] operandA,
    input aluPkg::aluOp opSelect,
    input logic start,
    output logic finished,
    output logic [DataWidth-1:0] zHighData,
    output logic [DataWidth-1:0] zLowData
);
    localparam int CountWidth = $clog2(DataWidth);

    aluPkg::aluState state;
    aluPkg::aluOp opReg;
    logic [CountWidth-1:0] count;
    logic [2*DataWidth-1:0] work;      // {acc or remainder, multiplier or quotient}
    logic [2*DataWidth-1:0] workNext;
    logic [DataWidth-1:0] operandReg;  // multiplicand or divisor
    logic [DataWidth-1:0] quickResult;
    logic [DataWidth:0] mulSum;
    logic [DataWidth:0] divTrial;
    logic [DataWidth:0] divDiff;
    logic [4:0] shiftAmount;
    int rotAmount;
    logic isMulDiv;
    logic lastStep;

    assign shiftAmount = bus.value[4:0];
    assign rotAmount = int'(shiftAmount) % DataWidth;
    assign isMulDiv = (opSelect == aluPkg::opMul) || (opSelect == aluPkg::opDiv);
    assign lastStep = (count == CountWidth'(DataWidth - 1));
    assign finished = (state == aluPkg::done);  // one-cycle pulse, done never holds

    // single-cycle ops, A from Y and B from the bus
    always_comb begin
        case (opSelect)
            aluPkg::opAdd: quickResult = operandA + bus.value;
            aluPkg::opSub: quickResult = operandA - bus.value;
            aluPkg::opAnd: quickResult = operandA & bus.value;
            aluPkg::opOr:  quickResult = operandA | bus.value;
            aluPkg::opShr: quickResult = operandA >> shiftAmount;
            aluPkg::opShl: quickResult = operandA << shiftAmount;
            aluPkg::opRor: quickResult = (operandA >> rotAmount) |
                                         (operandA << (DataWidth - rotAmount));
            aluPkg::opRol: quickResult = (operandA << rotAmount) |
                                         (operandA >> (DataWidth - rotAmount));
            aluPkg::opNeg: quickResult = -bus.value;
            aluPkg::opNot: quickResult = ~bus.value;
            default:       quickResult = '0;
        endcase
    end

    // one step of shift-and-add or restoring division
    always_comb begin
        mulSum = {1'b0, work[2*DataWidth-1:DataWidth]} +
                 (work[0] ? {1'b0, operandReg} : '0);
        divTrial = work[2*DataWidth-1:DataWidth-1];  // remainder shifted left, next bit in
        divDiff = divTrial - {1'b0, operandReg};
        if (opReg == aluPkg::opDiv) begin
            if (divDiff[DataWidth]) begin  // borrow, restore
                workNext = {divTrial[DataWidth-1:0], work[DataWidth-2:0], 1'b0};
            end else begin
                workNext = {divDiff[DataWidth-1:0], work[DataWidth-2:0], 1'b1};
            end
        end else begin
            workNext = {mulSum, work[DataWidth-1:1]};
        end
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            state <= aluPkg::idle;
            opReg <= aluPkg::opAdd;
            count <= '0;
            zHighData <= '0;
            zLowData <= '0;
        end else begin
            case (state)
                aluPkg::idle: begin
                    if (start) begin
                        opReg <= opSelect;
                        count <= '0;
                        if (isMulDiv) begin
                            state <= aluPkg::iterate;
                        end else begin
                            zHighData <= '0;
                            zLowData <= quickResult;
                            state <= aluPkg::done;
                        end
                    end
                end
                aluPkg::iterate: begin
                    count <= count + 1'b1;
                    if (lastStep) begin  // product, or remainder and quotient
                        zHighData <= workNext[2*DataWidth-1:DataWidth];
                        zLowData <= workNext[DataWidth-1:0];
                        state <= aluPkg::done;
                    end
                end
                default: state <= aluPkg::idle;
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (state == aluPkg::idle && start) begin
            if (opSelect == aluPkg::opMul) begin
                operandReg <= operandA;
                work <= {{DataWidth{1'b0}}, bus.value};
            end else begin
                operandReg <= bus.value;  // divisor
                work <= {{DataWidth{1'b0}}, operandA};
            end
        end else if (state == aluPkg::iterate) begin
            work <= workNext;
        end
    end
endmodule

// File: logic/dataPath.sv
// datapath top; strobes come straight from an external controller, no decode or memory here
`timescale 1ns/1ps

module dataPath #(
    parameter int DataWidth = dataPathPkg::dataWidth,
    parameter int RegCount = dataPathPkg::regCount
) (
    input logic Clock,
    input logic rstN,
    input logic rfOut, pcOut, irOut, yOut, zHighOut, zLowOut,
    input logic marOut, hiOut, loOut, mdrOut, extOut,
    input logic rfIn, pcIn, irIn, yIn, marIn, hiIn, loIn, mdrIn, read,
    input logic [dataPathPkg::regIndexWidth-1:0] rfSelect,
    input logic [DataWidth-1:0] memDataIn,
    input logic [DataWidth-1:0] extData,
    input aluPkg::aluOp opSelect,
    input logic start,
    output logic finished,
    output logic [DataWidth-1:0] busValue
);
    logic [DataWidth-1:0] regFileData, pcData, irData, yData, zHighData, zLowData;
    logic [DataWidth-1:0] marData, hiData, loData, mdrData;

    busIf #(.DataWidth(DataWidth)) bus ();

    assign bus.rfOut = rfOut;
    assign bus.pcOut = pcOut;
    assign bus.irOut = irOut;
    assign bus.yOut = yOut;
    assign bus.zHighOut = zHighOut;
    assign bus.zLowOut = zLowOut;
    assign bus.marOut = marOut;
    assign bus.hiOut = hiOut;
    assign bus.loOut = loOut;
    assign bus.mdrOut = mdrOut;
    assign bus.extOut = extOut;
    assign busValue = bus.value;

    busMux #(.DataWidth(DataWidth)) mux (
        .bus(bus), .regFileData, .pcData, .irData, .yData, .zHighData, .zLowData,
        .marData, .hiData, .loData, .mdrData, .extData
    );

    registerFile #(.DataWidth(DataWidth), .RegCount(RegCount)) regFile (
        .Clock, .rstN, .bus(bus), .rfSelect, .rfIn, .readData(regFileData)
    );

    memoryInterface #(.DataWidth(DataWidth)) memIf (
        .Clock, .rstN, .bus(bus), .marIn, .mdrIn, .read, .memDataIn, .marData, .mdrData
    );

    specialRegisters #(.DataWidth(DataWidth)) specRegs (
        .Clock, .rstN, .bus(bus), .pcIn, .irIn, .yIn, .hiIn, .loIn,
        .pcData, .irData, .yData, .hiData, .loData
    );

    // A operand is always Y
    alu #(.DataWidth(DataWidth)) aluUnit (
        .Clock, .rstN, .bus(bus), .operandA(yData), .opSelect, .start,
        .finished, .zHighData, .zLowData
    );
endmodule

// File: testbench/clockGen.sv
// free-running clock plus synchronous reset; rstN releases 2 ns after the last reset edge
`timescale 1ns/1ps

module clockGen #(
    parameter int ClockPeriod = 40,
    parameter int ResetCycles = 8
) (
    output logic Clock,
    output logic rstN
);
    initial begin
        Clock = 1'b0;
        forever #(ClockPeriod / 2) Clock = ~Clock;
    end

    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge Clock);
        #2 rstN = 1'b1;  // same offset as the stimulus
    end
endmodule

// File: testbench/dataPath_sva.sv
// protocol checks for any dataPath instance; assumes start is a single-cycle pulse
`timescale 1ns/1ps

module dataPathSva #(
    parameter int DataWidth = 32
) (
    input logic Clock,
    input logic rstN,
    input logic start,
    input logic finished,
    input logic [10:0] outStrobes,
    input logic [DataWidth-1:0] busValue
);
    logic startSeen;  // a start is still waiting for its finished

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            startSeen <= 1'b0;
        end else if (finished) begin
            startSeen <= 1'b0;
        end else if (start) begin
            startSeen <= 1'b1;
        end
    end

    finishedPulse: assert property (@(posedge Clock) disable iff (!rstN)
        finished |=> !finished)
        else $error("finished stayed high for two cycles");

    finishedAfterStart: assert property (@(posedge Clock) disable iff (!rstN)
        $rose(finished) |-> startSeen)
        else $error("finished rose with no start before it");

    idleBusZero: assert property (@(posedge Clock) disable iff (!rstN)
        (outStrobes == '0) |-> (busValue == '0))
        else $error("bus not zero while no output strobe is high");
endmodule

bind dataPath dataPathSva #(.DataWidth(DataWidth)) sva (
    .Clock, .rstN, .start, .finished, .busValue,
    .outStrobes({rfOut, pcOut, irOut, yOut, zHighOut, zLowOut,
                 marOut, hiOut, loOut, mdrOut, extOut})
);

// File: testbench/dataPathTb.sv
// acts as the control unit with plain strobes; expected values assume the 32-bit package widths
`timescale 1ns/1ps

module dataPathTb;
    localparam int DataWidth = dataPathPkg::dataWidth;
    localparam int IndexWidth = dataPathPkg::regIndexWidth;
    localparam int ClockPeriod = 40;
    localparam int ResetCycles = 8;
    localparam int TestCount = 5;
    localparam int FinishLimit = 100;  // cycles allowed for one ALU operation

    logic Clock;
    logic rstN;
    logic rfOut, pcOut, irOut, yOut, zHighOut, zLowOut, marOut, hiOut, loOut, mdrOut, extOut;
    logic rfIn, pcIn, irIn, yIn, marIn, hiIn, loIn, mdrIn, read;
    logic [IndexWidth-1:0] rfSelect;
    logic [DataWidth-1:0] memDataIn;
    logic [DataWidth-1:0] extData;
    logic [DataWidth-1:0] busValue;
    aluPkg::aluOp opSelect;
    logic start;
    logic finished;

    int mismatchCount = 0;
    int failureCount = 0;
    int seed = 32'h6b43;
    logic [DataWidth-1:0] regValues [dataPathPkg::regCount];

    clockGen #(.ClockPeriod(ClockPeriod), .ResetCycles(ResetCycles)) clocks (.Clock, .rstN);

    dataPath DUT (.*);

    // expected single-cycle results, shifts by the low 5 bits of B
    function automatic logic [DataWidth-1:0] quickModel(input aluPkg::aluOp op,
            input logic [DataWidth-1:0] a, input logic [DataWidth-1:0] b);
        logic [4:0] n;
        logic [2*DataWidth-1:0] shifted;
        n = b[4:0];
        case (op)
            aluPkg::opAdd: return a + b;
            aluPkg::opSub: return a - b;
            aluPkg::opAnd: return a & b;
            aluPkg::opOr:  return a | b;
            aluPkg::opShr: return a >> n;
            aluPkg::opShl: return a << n;
            aluPkg::opRor: begin
                shifted = {a, a} >> n;
                return shifted[DataWidth-1:0];
            end
            aluPkg::opRol: begin
                shifted = {a, a} << n;
                return shifted[2*DataWidth-1:DataWidth];
            end
            aluPkg::opNeg: return '0 - b;
            aluPkg::opNot: return ~b;
            default:       return '0;
        endcase
    endfunction

    // unsigned product, or {remainder, quotient}
    function automatic logic [2*DataWidth-1:0] longModel(input aluPkg::aluOp op,
            input logic [DataWidth-1:0] a, input logic [DataWidth-1:0] b);
        logic [2*DataWidth-1:0] wideA;
        logic [2*DataWidth-1:0] wideB;
        wideA = {{DataWidth{1'b0}}, a};
        wideB = {{DataWidth{1'b0}}, b};
        if (op == aluPkg::opMul) return wideA * wideB;
        if (b == '0) return {a, {DataWidth{1'b1}}};
        return {a % b, a / b};
    endfunction

    task automatic stepCycle();
        @(posedge Clock);
        #2;
    endtask

    task automatic clearControls();
        {rfOut, pcOut, irOut, yOut, zHighOut, zLowOut} = '0;
        {marOut, hiOut, loOut, mdrOut, extOut} = '0;
        {rfIn, pcIn, irIn, yIn, marIn, hiIn, loIn, mdrIn, read} = '0;
        start = 1'b0;
    endtask

    task automatic checkValue(input string name, input logic [DataWidth-1:0] got,
            input logic [DataWidth-1:0] exp);
        assert (got === exp) else begin
            mismatchCount++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // one output strobe high, all others low
    task automatic setOut(input dataPathPkg::busSource src);
        {rfOut, pcOut, irOut, yOut, zHighOut, zLowOut} = '0;
        {marOut, hiOut, loOut, mdrOut, extOut} = '0;
        case (src)
            dataPathPkg::regFile:  rfOut = 1'b1;
            dataPathPkg::pc:       pcOut = 1'b1;
            dataPathPkg::ir:       irOut = 1'b1;
            dataPathPkg::y:        yOut = 1'b1;
            dataPathPkg::zHigh:    zHighOut = 1'b1;
            dataPathPkg::zLow:     zLowOut = 1'b1;
            dataPathPkg::mar:      marOut = 1'b1;
            dataPathPkg::hi:       hiOut = 1'b1;
            dataPathPkg::lo:       loOut = 1'b1;
            dataPathPkg::mdr:      mdrOut = 1'b1;
            dataPathPkg::external: extOut = 1'b1;
            default: ;
        endcase
    endtask

    // value goes in through extData; register file index comes from rfSelect
    task automatic loadReg(input dataPathPkg::busSource dest, input logic [DataWidth-1:0] value);
        setOut(dataPathPkg::external);
        extData = value;
        case (dest)
            dataPathPkg::regFile: rfIn = 1'b1;
            dataPathPkg::pc:      pcIn = 1'b1;
            dataPathPkg::ir:      irIn = 1'b1;
            dataPathPkg::y:       yIn = 1'b1;
            dataPathPkg::mar:     marIn = 1'b1;
            dataPathPkg::hi:      hiIn = 1'b1;
            dataPathPkg::lo:      loIn = 1'b1;
            dataPathPkg::mdr:     mdrIn = 1'b1;
            default: ;
        endcase
        stepCycle();
        clearControls();
    endtask

    task automatic checkSource(input dataPathPkg::busSource src, input logic [DataWidth-1:0] exp);
        setOut(src);
        #1;
        checkValue($sformatf("busValue (%s)", src.name()), busValue, exp);
        stepCycle();
    endtask

    task automatic waitFinished(input string what);
        int cycles;
        cycles = 0;
        while (!finished && cycles < FinishLimit) begin
            stepCycle();
            cycles++;
        end
        assert (finished) else begin
            failureCount++;
            $display("finished did not arrive within %0d cycles after starting %s",
                     FinishLimit, what);
        end
    endtask

    // A through Y, B on the bus; restart fires a second start while busy
    task automatic runAlu(input aluPkg::aluOp op, input logic [DataWidth-1:0] a,
            input logic [DataWidth-1:0] b, input bit restart,
            output logic [2*DataWidth-1:0] z);
        logic [DataWidth-1:0] zLow;
        logic [DataWidth-1:0] zHigh;
        loadReg(dataPathPkg::y, a);
        setOut(dataPathPkg::external);
        extData = b;
        opSelect = op;
        start = 1'b1;
        stepCycle();
        start = 1'b0;
        if (restart) begin
            repeat (3) stepCycle();
            opSelect = aluPkg::opAdd;  // would change Z if it were accepted
            extData = ~b;
            start = 1'b1;
            stepCycle();
            start = 1'b0;
        end
        waitFinished(op.name());
        setOut(dataPathPkg::zLow);
        #1 zLow = busValue;
        stepCycle();
        setOut(dataPathPkg::zHigh);
        #1 zHigh = busValue;
        stepCycle();
        clearControls();
        z = {zHigh, zLow};
    endtask

    task automatic checkLong(input aluPkg::aluOp op, input logic [DataWidth-1:0] a,
            input logic [DataWidth-1:0] b, input bit restart);
        logic [2*DataWidth-1:0] z;
        logic [2*DataWidth-1:0] exp;
        runAlu(op, a, b, restart, z);
        exp = longModel(op, a, b);
        checkValue($sformatf("%s Z low", op.name()), z[DataWidth-1:0], exp[DataWidth-1:0]);
        checkValue($sformatf("%s Z high", op.name()), z[2*DataWidth-1:DataWidth],
                   exp[2*DataWidth-1:DataWidth]);
    endtask

    task automatic testReset();
        clearControls();
        #1;
        checkValue("busValue with no strobe", busValue, '0);
        checkValue("finished", DataWidth'(finished), '0);
        stepCycle();
        for (int i = 1; i <= 10; i++) begin
            checkSource(dataPathPkg::busSource'(i), '0);
        end
    endtask

    task automatic testRegisterFile();
        for (int i = 0; i < dataPathPkg::regCount; i++) begin
            regValues[i] = $random(seed);
            rfSelect = IndexWidth'(i);
            loadReg(dataPathPkg::regFile, regValues[i]);
        end
        for (int i = 0; i < dataPathPkg::regCount; i++) begin
            rfSelect = IndexWidth'(i);
            checkSource(dataPathPkg::regFile, regValues[i]);
        end
        rfSelect = IndexWidth'(5);
        setOut(dataPathPkg::regFile);
        extOut = 1'b1;  // lower priority than rfOut
        extData = ~regValues[5];
        #1;
        checkValue("busValue (rfOut with extOut)", busValue, regValues[5]);
        stepCycle();
    endtask

    task automatic testSpecialRegisters();
        dataPathPkg::busSource dests [6];
        logic [DataWidth-1:0] values [6];
        logic [DataWidth-1:0] word;
        dests = '{dataPathPkg::pc, dataPathPkg::ir, dataPathPkg::y,
                  dataPathPkg::hi, dataPathPkg::lo, dataPathPkg::mar};
        for (int i = 0; i < 6; i++) begin
            values[i] = $random(seed);
            loadReg(dests[i], values[i]);
        end
        for (int i = 0; i < 6; i++) begin
            checkSource(dests[i], values[i]);
        end
        word = $random(seed);
        setOut(dataPathPkg::external);
        extData = ~word;  // bus holds something else while reading memory
        memDataIn = word;
        read = 1'b1;
        mdrIn = 1'b1;
        stepCycle();
        clearControls();
        checkSource(dataPathPkg::mdr, word);
        word = $random(seed);
        loadReg(dataPathPkg::mdr, word);
        checkSource(dataPathPkg::mdr, word);
        // 2 through the MDR into R2, then Y = R2 and shift left by R2
        memDataIn = DataWidth'(2);
        read = 1'b1;
        mdrIn = 1'b1;
        stepCycle();
        clearControls();
        setOut(dataPathPkg::mdr);
        rfSelect = IndexWidth'(2);
        rfIn = 1'b1;
        stepCycle();
        clearControls();
        setOut(dataPathPkg::regFile);
        yIn = 1'b1;
        stepCycle();
        clearControls();
        setOut(dataPathPkg::regFile);
        opSelect = aluPkg::opShl;
        start = 1'b1;
        stepCycle();
        start = 1'b0;
        waitFinished("opShl");
        checkSource(dataPathPkg::zLow, DataWidth'(8));
        checkSource(dataPathPkg::zHigh, '0);
    endtask

    task automatic testQuickOps();
        aluPkg::aluOp ops [10];
        logic [DataWidth-1:0] a;
        logic [DataWidth-1:0] b;
        logic [2*DataWidth-1:0] z;
        ops = '{aluPkg::opAdd, aluPkg::opSub, aluPkg::opAnd, aluPkg::opOr, aluPkg::opShr,
                aluPkg::opShl, aluPkg::opRor, aluPkg::opRol, aluPkg::opNeg, aluPkg::opNot};
        for (int i = 0; i < 10; i++) begin
            // full-width product leaves Z high nonzero ahead of each opcode
            checkLong(aluPkg::opMul, {DataWidth{1'b1}}, {DataWidth{1'b1}}, 1'b0);
            for (int k = 0; k < 3; k++) begin
                a = $random(seed);
                b = $random(seed);
                runAlu(ops[i], a, b, 1'b0, z);
                checkValue($sformatf("%s Z low", ops[i].name()), z[DataWidth-1:0],
                           quickModel(ops[i], a, b));
                checkValue($sformatf("%s Z high", ops[i].name()),
                           z[2*DataWidth-1:DataWidth], '0);
            end
        end
    endtask

    task automatic testLongOps();
        logic [DataWidth-1:0] a;
        logic [DataWidth-1:0] b;
        a = $random(seed);
        b = $random(seed);
        checkLong(aluPkg::opMul, a, b, 1'b0);
        checkLong(aluPkg::opMul, {DataWidth{1'b1}}, {DataWidth{1'b1}}, 1'b0);
        checkLong(aluPkg::opMul, '0, b, 1'b0);
        checkLong(aluPkg::opDiv, a, b, 1'b0);
        checkLong(aluPkg::opDiv, a, b >> 20, 1'b0);  // small divisor, wide quotient
        checkLong(aluPkg::opDiv, a, '0, 1'b0);
        checkLong(aluPkg::opDiv, {DataWidth{1'b1}}, DataWidth'(1), 1'b0);
        a = $random(seed);
        b = $random(seed);
        checkLong(aluPkg::opMul, a, b, 1'b1);
        checkLong(aluPkg::opDiv, a, b >> 12, 1'b1);
    endtask

    initial begin
        clearControls();
        rfSelect = '0;
        memDataIn = '0;
        extData = '0;
        opSelect = aluPkg::opAdd;
        @(posedge rstN);
        testReset();
        testRegisterFile();
        testSpecialRegisters();
        testQuickOps();
        testLongOps();
        $display("error counts: %0d mismatches, %0d other failures",
                 mismatchCount, failureCount);
        if (mismatchCount == 0 && failureCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((TestCount * 200 + ResetCycles) * ClockPeriod);
        $display("watchdog expired before the tests completed");
        $display("TEST FAILED");
        $finish;
    end
endmodule

// File: verilog.f
logic/dataPathPkg.sv
logic/aluPkg.sv
logic/busIf.sv
logic/busMux.sv
logic/registerFile.sv
logic/memoryInterface.sv
logic/specialRegisters.sv
logic/alu.sv
logic/dataPath.sv
testbench/clockGen.sv
testbench/dataPath_sva.sv
testbench/dataPathTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build the datapath testbench with Verilator, run it and judge the log.
set -u
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module dataPathTb -o simDataPath
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/simDataPath > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "TEST FAILED" "$logFile"; then
    exit 1
fi
if ! grep -q "TEST PASSED" "$logFile"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
